/* logic/decode_pkg.sv */
// decode package with the widths, vector types, class encodings and opcodes of the ID stage
package decode_pkg;

    // widths fixed by RV64I
    localparam int XLEN  = 64;
    localparam int ILEN  = 32;
    localparam int NREGS = 32;
    localparam int RIDX  = 5;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     addr_t;
    typedef logic [ILEN-1:0] inst_t;
    typedef logic [RIDX-1:0] reg_idx_t;
    typedef logic [3:0]      alu_op_t;
    typedef logic [2:0]      func3_t;

    // instruction class, unknown opcodes land in CLS_NONE
    typedef enum logic [3:0] {
        CLS_NONE   = 4'd0,
        CLS_LUI    = 4'd1,
        CLS_AUIPC  = 4'd2,
        CLS_JAL    = 4'd3,
        CLS_JALR   = 4'd4,
        CLS_BRANCH = 4'd5,
        CLS_LOAD   = 4'd6,
        CLS_STORE  = 4'd7,
        CLS_ALU_I  = 4'd8,
        CLS_ALU_R  = 4'd9,
        CLS_ALU_IW = 4'd10,
        CLS_ALU_W  = 4'd11
    } inst_class_e;

    // where the writeback value of rd comes from
    typedef enum logic [1:0] {
        RD_ALU  = 2'd0,
        RD_LINK = 2'd1,
        RD_IMM  = 2'd2
    } rd_sel_e;

    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_ALU_I  = 7'b0010011;
    localparam logic [6:0] OPC_ALU_R  = 7'b0110011;
    localparam logic [6:0] OPC_ALU_IW = 7'b0011011;
    localparam logic [6:0] OPC_ALU_W  = 7'b0111011;

endpackage

/* logic/inst_classify.sv */
// instruction classifier producing the class and the execute controls from one word
module inst_classify import decode_pkg::*; (
    input  inst_t       inst_i,
    output inst_class_e class_o,
    output alu_op_t     alu_op_o,
    output logic        sub_o,
    output logic        sra_o,
    output logic        src1_pc_o,
    output logic        src2_imm_o,
    output logic        rd_write_o,
    output rd_sel_e     rd_sel_o
);

    logic [6:0] opcode;
    func3_t     func3;
    logic [6:0] func7;
    logic       is_alu;
    logic       is_reg_alu;

    assign opcode = inst_i[6:0];
    assign func3  = inst_i[14:12];
    assign func7  = inst_i[31:25];

    // opcode to class
    always_comb begin
        case (opcode)
            OPC_LUI:    class_o = CLS_LUI;
            OPC_AUIPC:  class_o = CLS_AUIPC;
            OPC_JAL:    class_o = CLS_JAL;
            OPC_JALR:   class_o = CLS_JALR;
            OPC_BRANCH: class_o = CLS_BRANCH;
            OPC_LOAD:   class_o = CLS_LOAD;
            OPC_STORE:  class_o = CLS_STORE;
            OPC_ALU_I:  class_o = CLS_ALU_I;
            OPC_ALU_R:  class_o = CLS_ALU_R;
            OPC_ALU_IW: class_o = CLS_ALU_IW;
            OPC_ALU_W:  class_o = CLS_ALU_W;
            default:    class_o = CLS_NONE;
        endcase
    end

    // register-register forms carry func7 into the op code
    assign is_reg_alu = (class_o == CLS_ALU_R) || (class_o == CLS_ALU_W);
    assign is_alu     = is_reg_alu || (class_o == CLS_ALU_I) || (class_o == CLS_ALU_IW);

    always_comb begin
        case (class_o)
            CLS_ALU_R,
            CLS_ALU_W: begin
                alu_op_o = {func7[0], func3};
            end
            CLS_ALU_I,
            CLS_ALU_IW: begin
                alu_op_o = {1'b0, func3};
            end
            default: begin
                alu_op_o = 4'd0;
            end
        endcase
    end

    assign sub_o = is_reg_alu && (func3 == 3'b000) && (func7 == 7'b0100000);

    // srai keeps shamt[5] in func7[0], so only the upper six bits are compared
    assign sra_o = is_alu && (func3 == 3'b101) && (func7[6:1] == 6'b010000);

    // operand selects
    always_comb begin
        case (class_o)
            CLS_AUIPC,
            CLS_JAL,
            CLS_BRANCH: src1_pc_o = 1'b1;
            default:    src1_pc_o = 1'b0;
        endcase
    end

    always_comb begin
        case (class_o)
            CLS_ALU_I,
            CLS_ALU_IW,
            CLS_AUIPC,
            CLS_JAL,
            CLS_JALR,
            CLS_BRANCH: src2_imm_o = 1'b1;
            default:    src2_imm_o = 1'b0;
        endcase
    end

    // destination write enable and source
    always_comb begin
        case (class_o)
            CLS_ALU_I,
            CLS_ALU_R,
            CLS_ALU_IW,
            CLS_ALU_W,
            CLS_LOAD,
            CLS_LUI,
            CLS_AUIPC,
            CLS_JAL,
            CLS_JALR: rd_write_o = 1'b1;
            default:  rd_write_o = 1'b0;
        endcase
    end

    always_comb begin
        case (class_o)
            CLS_LUI: begin
                rd_sel_o = RD_IMM;
            end
            CLS_JAL,
            CLS_JALR: begin
                rd_sel_o = RD_LINK;
            end
            default: begin
                rd_sel_o = RD_ALU;
            end
        endcase
    end

endmodule

/* logic/imm_gen.sv */
// immediate generator selecting the RV64I format by class and sign-extending to 64 bits
module imm_gen import decode_pkg::*; (
    input  inst_t       inst_i,
    input  inst_class_e class_i,
    output xlen_t       imm_o
);

    logic  sgn;
    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_j;
    xlen_t imm_u;

    assign sgn = inst_i[31];

    assign imm_i = {{(XLEN-12){sgn}}, inst_i[31:20]};
    assign imm_s = {{(XLEN-12){sgn}}, inst_i[31:25], inst_i[11:7]};

    // branch and jump offsets are in halfwords
    assign imm_b = {{(XLEN-13){sgn}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_j = {{(XLEN-21){sgn}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    assign imm_u = {{(XLEN-32){sgn}}, inst_i[31:12], 12'b0};

    always_comb begin
        case (class_i)
            CLS_ALU_I,
            CLS_ALU_IW,
            CLS_LOAD,
            CLS_JALR:   imm_o = imm_i;
            CLS_STORE:  imm_o = imm_s;
            CLS_BRANCH: imm_o = imm_b;
            CLS_JAL:    imm_o = imm_j;
            CLS_LUI,
            CLS_AUIPC:  imm_o = imm_u;
            default:    imm_o = '0;
        endcase
    end

endmodule

/* logic/reg_file.sv */
// integer register file with one writeback port and two forwarding read ports
module reg_file import decode_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  logic     wb_write_i,
    input  reg_idx_t wb_rd_i,
    input  xlen_t    wb_data_i,
    output xlen_t    rs1_data_o,
    output xlen_t    rs2_data_o
);

    xlen_t regs [NREGS];

    // x0 stays hardwired to zero on both paths
    function automatic xlen_t read_port(input reg_idx_t idx);
        xlen_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wb_write_i && (wb_rd_i == idx)) begin
            val = wb_data_i;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write_i && (wb_rd_i != '0)) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // same-cycle writeback bypasses the array
    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

/* logic/decode_stage.sv */
// RV64I decode stage registering operands, immediate and execute controls toward EX
module decode_stage import decode_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        id_valid_i,
    input  inst_t       id_inst_i,
    input  addr_t       id_pc_i,
    input  logic        flush_i,
    input  logic        ex_ready_i,

    input  logic        wb_write_i,
    input  reg_idx_t    wb_rd_i,
    input  xlen_t       wb_data_i,

    output logic        id_ready_o,
    output logic        ex_valid_o,
    output addr_t       ex_pc_o,
    output inst_class_e ex_class_o,
    output reg_idx_t    ex_rs1_o,
    output reg_idx_t    ex_rs2_o,
    output reg_idx_t    ex_rd_o,
    output xlen_t       ex_rs1_data_o,
    output xlen_t       ex_rs2_data_o,
    output xlen_t       ex_imm_o,
    output func3_t      ex_func3_o,
    output alu_op_t     ex_alu_op_o,
    output logic        ex_sub_o,
    output logic        ex_sra_o,
    output logic        ex_src1_pc_o,
    output logic        ex_src2_imm_o,
    output logic        ex_rd_write_o,
    output rd_sel_e     ex_rd_sel_o
);

    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    func3_t      func3;

    inst_class_e cls;
    alu_op_t     alu_op;
    logic        sub;
    logic        sra;
    logic        src1_pc;
    logic        src2_imm;
    logic        rd_write;
    rd_sel_e     rd_sel;
    xlen_t       imm;
    xlen_t       rs1_data;
    xlen_t       rs2_data;

    // instruction fields
    assign rd    = id_inst_i[11:7];
    assign func3 = id_inst_i[14:12];
    assign rs1   = id_inst_i[19:15];
    assign rs2   = id_inst_i[24:20];

    // stall propagates straight back to fetch
    assign id_ready_o = ex_ready_i;

    inst_classify u_classify (
        .inst_i     (id_inst_i),
        .class_o    (cls),
        .alu_op_o   (alu_op),
        .sub_o      (sub),
        .sra_o      (sra),
        .src1_pc_o  (src1_pc),
        .src2_imm_o (src2_imm),
        .rd_write_o (rd_write),
        .rd_sel_o   (rd_sel)
    );

    imm_gen u_imm (
        .inst_i  (id_inst_i),
        .class_i (cls),
        .imm_o   (imm)
    );

    reg_file u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wb_write_i (wb_write_i),
        .wb_rd_i    (wb_rd_i),
        .wb_data_i  (wb_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // ID/EX pipeline register, held while EX is stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid_o    <= 1'b0;
            ex_pc_o       <= '0;
            ex_class_o    <= CLS_NONE;
            ex_rs1_o      <= '0;
            ex_rs2_o      <= '0;
            ex_rd_o       <= '0;
            ex_rs1_data_o <= '0;
            ex_rs2_data_o <= '0;
            ex_imm_o      <= '0;
            ex_func3_o    <= '0;
            ex_alu_op_o   <= '0;
            ex_sub_o      <= 1'b0;
            ex_sra_o      <= 1'b0;
            ex_src1_pc_o  <= 1'b0;
            ex_src2_imm_o <= 1'b0;
            ex_rd_write_o <= 1'b0;
            ex_rd_sel_o   <= RD_ALU;
        end else if (ex_ready_i) begin
            // a flush only kills valid, the payload still moves
            ex_valid_o    <= id_valid_i && !flush_i;
            ex_pc_o       <= id_pc_i;
            ex_class_o    <= cls;
            ex_rs1_o      <= rs1;
            ex_rs2_o      <= rs2;
            ex_rd_o       <= rd;
            ex_rs1_data_o <= rs1_data;
            ex_rs2_data_o <= rs2_data;
            ex_imm_o      <= imm;
            ex_func3_o    <= func3;
            ex_alu_op_o   <= alu_op;
            ex_sub_o      <= sub;
            ex_sra_o      <= sra;
            ex_src1_pc_o  <= src1_pc;
            ex_src2_imm_o <= src2_imm;
            ex_rd_write_o <= rd_write;
            ex_rd_sel_o   <= rd_sel;
        end
    end

endmodule

/* bench/decode_model.svh */
// reference model of the decode stage with class, immediate, control rules and a shadow register file
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
    alu_op_t alu_op;
    logic    sub;
    logic    sra;
    logic    src1_pc;
    logic    src2_imm;
    logic    rd_write;
    rd_sel_e rd_sel;
} ctrl_t;

xlen_t shadow [NREGS];

function automatic inst_class_e model_class(input inst_t inst);
    inst_class_e c;
    case (inst[6:0])
        OPC_LUI:    c = CLS_LUI;
        OPC_AUIPC:  c = CLS_AUIPC;
        OPC_JAL:    c = CLS_JAL;
        OPC_JALR:   c = CLS_JALR;
        OPC_BRANCH: c = CLS_BRANCH;
        OPC_LOAD:   c = CLS_LOAD;
        OPC_STORE:  c = CLS_STORE;
        OPC_ALU_I:  c = CLS_ALU_I;
        OPC_ALU_R:  c = CLS_ALU_R;
        OPC_ALU_IW: c = CLS_ALU_IW;
        OPC_ALU_W:  c = CLS_ALU_W;
        default:    c = CLS_NONE;
    endcase
    return c;
endfunction

// build a 32-bit immediate first, then widen from its top bit
function automatic xlen_t model_imm(input inst_t inst, input inst_class_e c);
    logic [31:0] v;
    case (c)
        CLS_ALU_I, CLS_ALU_IW, CLS_LOAD, CLS_JALR: v = {{20{inst[31]}}, inst[31:20]};
        CLS_STORE:  v = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        CLS_BRANCH: v = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        CLS_JAL:    v = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        CLS_LUI, CLS_AUIPC: v = {inst[31:12], 12'h000};
        default:    v = '0;
    endcase
    return {{32{v[31]}}, v};
endfunction

function automatic ctrl_t model_ctrl(input inst_t inst);
    ctrl_t       k;
    inst_class_e c;
    logic        reg_form;
    logic        any_alu;
    c        = model_class(inst);
    reg_form = (c == CLS_ALU_R) || (c == CLS_ALU_W);
    any_alu  = reg_form || (c == CLS_ALU_I) || (c == CLS_ALU_IW);
    k        = '0;
    if (reg_form) begin
        k.alu_op = {inst[25], inst[14:12]};
    end else if (any_alu) begin
        k.alu_op = {1'b0, inst[14:12]};
    end
    k.sub      = reg_form && (inst[14:12] == 3'b000) && (inst[31:25] == 7'b0100000);
    k.sra      = any_alu && (inst[14:12] == 3'b101) && (inst[31:26] == 6'b010000);
    k.src1_pc  = c inside {CLS_AUIPC, CLS_JAL, CLS_BRANCH};
    k.src2_imm = any_alu && !reg_form || (c inside {CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_BRANCH});
    k.rd_write = any_alu || (c inside {CLS_LOAD, CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR});
    k.rd_sel   = (c == CLS_LUI) ? RD_IMM : ((c == CLS_JAL) || (c == CLS_JALR)) ? RD_LINK : RD_ALU;
    return k;
endfunction

// x0 reads zero, otherwise a same-cycle write wins over the stored value
function automatic xlen_t shadow_read(input reg_idx_t idx, input logic wr,
                                      input reg_idx_t wr_idx, input xlen_t wr_data);
    if (idx == 5'd0) begin
        return '0;
    end
    if (wr && (wr_idx == idx)) begin
        return wr_data;
    end
    return shadow[idx];
endfunction

task automatic shadow_write(input logic wr, input reg_idx_t idx, input xlen_t data);
    if (wr && (idx != 5'd0)) begin
        shadow[idx] = data;
    end
endtask

task automatic shadow_clear();
    for (int i = 0; i < NREGS; i++) begin
        shadow[i] = '0;
    end
endtask

`endif

/* bench/tb_decode_stage.sv */
// testbench for the decode stage, checking every EX-side output against a reference model
module tb_decode_stage import decode_pkg::*; ();

    logic        clk = 1'b0;
    logic        rst_n;
    logic        id_valid_i;
    inst_t       id_inst_i;
    addr_t       id_pc_i;
    logic        flush_i;
    logic        ex_ready_i;
    logic        wb_write_i;
    reg_idx_t    wb_rd_i;
    xlen_t       wb_data_i;
    logic        id_ready_o;
    logic        ex_valid_o;
    addr_t       ex_pc_o;
    inst_class_e ex_class_o;
    reg_idx_t    ex_rs1_o;
    reg_idx_t    ex_rs2_o;
    reg_idx_t    ex_rd_o;
    xlen_t       ex_rs1_data_o;
    xlen_t       ex_rs2_data_o;
    xlen_t       ex_imm_o;
    func3_t      ex_func3_o;
    alu_op_t     ex_alu_op_o;
    logic        ex_sub_o;
    logic        ex_sra_o;
    logic        ex_src1_pc_o;
    logic        ex_src2_imm_o;
    logic        ex_rd_write_o;
    rd_sel_e     ex_rd_sel_o;

    // what EX should hold, taken at the last accepting edge
    logic        e_valid;
    inst_t       e_inst;
    addr_t       e_pc;
    xlen_t       e_rs1_data;
    xlen_t       e_rs2_data;

    integer      seed;
    int          errors = 0;

    localparam logic [6:0] OPC_LIST [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
        OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_ALU_I, OPC_ALU_R, OPC_ALU_IW, OPC_ALU_W};

    `include "decode_model.svh"

    decode_stage uut (.*);

    always #20 clk = ~clk;

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want) else begin
            errors++;
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, want);
        end
    endtask

    // an all-zero instruction word predicts the reset values as well
    task automatic check_outputs();
        ctrl_t       k;
        inst_class_e c;
        c = model_class(e_inst);
        k = model_ctrl(e_inst);
        check_field("id_ready_o", 64'(id_ready_o), 64'(ex_ready_i));
        check_field("ex_valid_o", 64'(ex_valid_o), 64'(e_valid));
        check_field("ex_pc_o", 64'(ex_pc_o), 64'(e_pc));
        check_field("ex_class_o", 64'(ex_class_o), 64'(c));
        check_field("ex_rs1_o", 64'(ex_rs1_o), 64'(e_inst[19:15]));
        check_field("ex_rs2_o", 64'(ex_rs2_o), 64'(e_inst[24:20]));
        check_field("ex_rd_o", 64'(ex_rd_o), 64'(e_inst[11:7]));
        check_field("ex_rs1_data_o", ex_rs1_data_o, e_rs1_data);
        check_field("ex_rs2_data_o", ex_rs2_data_o, e_rs2_data);
        check_field("ex_imm_o", ex_imm_o, model_imm(e_inst, c));
        check_field("ex_func3_o", 64'(ex_func3_o), 64'(e_inst[14:12]));
        check_field("ex_alu_op_o", 64'(ex_alu_op_o), 64'(k.alu_op));
        check_field("ex_sub_o", 64'(ex_sub_o), 64'(k.sub));
        check_field("ex_sra_o", 64'(ex_sra_o), 64'(k.sra));
        check_field("ex_src1_pc_o", 64'(ex_src1_pc_o), 64'(k.src1_pc));
        check_field("ex_src2_imm_o", 64'(ex_src2_imm_o), 64'(k.src2_imm));
        check_field("ex_rd_write_o", 64'(ex_rd_write_o), 64'(k.rd_write));
        check_field("ex_rd_sel_o", 64'(ex_rd_sel_o), 64'(k.rd_sel));
    endtask

    task automatic drive_random(input logic ready);
        logic [31:0] r;
        logic [3:0]  sel;
        r         = $random(seed);
        sel       = r[19:16];
        id_inst_i = $random(seed);
        // most words carry a real opcode, the rest stay fully random
        if (sel < 4'd11) begin
            id_inst_i[6:0] = OPC_LIST[sel];
        end
        if (r[0]) begin
            id_inst_i[31:25] = {6'b010000, r[1]};
        end
        id_pc_i    = $random(seed);
        id_valid_i = r[3:2] != 2'b00;
        flush_i    = r[6:4] == 3'b000;
        ex_ready_i = ready;
        wb_write_i = r[7];
        wb_data_i  = {$random(seed), $random(seed)};
        // steer writebacks onto the source fields and onto x0
        case (r[10:8])
            3'd0, 3'd1: wb_rd_i = id_inst_i[19:15];
            3'd2:       wb_rd_i = id_inst_i[24:20];
            3'd3: begin
                id_inst_i[19:15] = 5'd0;
                wb_rd_i          = 5'd0;
            end
            default:    wb_rd_i = r[15:11];
        endcase
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        @(posedge clk);
        while (!id_ready_o && (n < limit)) begin
            @(posedge clk);
            n++;
        end
        if (!id_ready_o) begin
            $display("timeout: id_ready_o stayed low for %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end else begin
            #5;
        end
    endtask

    initial begin
        int stall;
        seed       = 32'h9472_349e;
        rst_n      = 1'b0;
        id_valid_i = 1'b0;
        id_inst_i  = '0;
        id_pc_i    = '0;
        flush_i    = 1'b0;
        ex_ready_i = 1'b0;
        wb_write_i = 1'b0;
        wb_rd_i    = '0;
        wb_data_i  = '0;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
        end
        #5;
        rst_n = 1'b1;
        for (int i = 0; i < 400; i++) begin
            drive_random(1'b1);
            wait_ready(8);
        end
        // EX stalls of random length with inputs still moving
        for (int i = 0; i < 40; i++) begin
            stall = 1 + ($unsigned($random(seed)) % 6);
            for (int j = 0; j < stall; j++) begin
                drive_random(1'b0);
                @(posedge clk);
                #5;
            end
            drive_random(1'b1);
            wait_ready(8);
        end
        id_valid_i = 1'b0;
        wb_write_i = 1'b0;
        wait_ready(8);
        $display("decode checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                e_valid    = 1'b0;
                e_inst     = '0;
                e_pc       = '0;
                e_rs1_data = '0;
                e_rs2_data = '0;
                shadow_clear();
            end else begin
                if (ex_ready_i) begin
                    e_valid    = id_valid_i && !flush_i;
                    e_inst     = id_inst_i;
                    e_pc       = id_pc_i;
                    e_rs1_data = shadow_read(id_inst_i[19:15], wb_write_i, wb_rd_i, wb_data_i);
                    e_rs2_data = shadow_read(id_inst_i[24:20], wb_write_i, wb_rd_i, wb_data_i);
                end
                shadow_write(wb_write_i, wb_rd_i, wb_data_i);
            end
            #1;
            check_outputs();
        end
    end

endmodule

/* build.f */
+incdir+bench
logic/decode_pkg.sv
logic/inst_classify.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/decode_stage.sv
bench/tb_decode_stage.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

if ! cd "$(dirname "$0")"; then
    echo "cannot enter the project directory"
    exit 1
fi

if ! verilator --binary --timing --assert -f build.f --top-module tb_decode_stage -o sim_decode; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_decode > sim.log 2>&1; then
    cat sim.log
    echo "simulator exited with an error"
    exit 1
fi

cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
